// File: compile.f
+incdir+design
design/mips_ex_pkg.sv
design/credit_link_if.sv
design/credit_fifo.sv
design/alu.sv
design/ex_stage.sv
design/ex_unit_top.sv
sim/ex_unit_props.sv
sim/ex_unit_tb.sv

// File: Bender.yml
package:
  name: mips_ex_unit

sources:
  - include_dirs:
      - design
    files:
      - design/mips_ex_pkg.sv
      - design/credit_link_if.sv
      - design/credit_fifo.sv
      - design/alu.sv
      - design/ex_stage.sv
      - design/ex_unit_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/ex_unit_props.sv
      - sim/ex_unit_tb.sv

// File: sim/ex_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_ex_macros.svh"

module ex_unit_tb
    import mips_ex_pkg::*;
();

    typedef struct {
        alu_op_e          op;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] imm;
        logic             src;
        logic [1:0]       dsel;
        logic [4:0]       sh;
        logic             nop;
        logic [`XLEN-1:0] res;
    } row_t;

    typedef struct {
        ex_mem_t m;
        logic    nop;
        int      idx;
    } exp_t;

    logic    clk;
    logic    rst;
    logic    in_valid;
    logic    in_nop;
    id_ex_t  in_entry;
    logic    out_credit;
    logic    in_credit;
    logic    out_valid;
    logic    out_nop;
    ex_mem_t out_entry;

    row_t rows[$];
    exp_t exp_q[$];
    int   seed = 32'hb98e3e9b;
    int   up_credits = `EX_CREDITS;
    int   owed = 0;
    int   hold = 0;
    bit   withhold = 0;
    bit   random_mode = 0;
    bit   table_ready = 0;
    int   sent = 0;
    int   received = 0;
    int   checks = 0;
    int   errors = 0;

    ex_unit_top UUT (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_nop     (in_nop),
        .in_entry   (in_entry),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_nop    (out_nop),
        .out_entry  (out_entry)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic add_row(input alu_op_e op, input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] imm, input logic src, input logic [1:0] dsel,
                           input logic [4:0] sh, input logic nop, input logic [31:0] res);
        row_t r;
        r = '{op, a, b, imm, src, dsel, sh, nop, res};
        rows.push_back(r);
    endtask

    task automatic build_table();
        // Expected results worked out by hand from the MIPS ALU rules.
        add_row(ALU_ADD,  32'h0000_0005, 32'h0000_0007, 32'h0, 0, 1, 0,  0, 32'h0000_000c);
        add_row(ALU_SUB,  32'h0000_0007, 32'h0000_0007, 32'h0, 0, 1, 0,  0, 32'h0000_0000);
        add_row(ALU_SUB,  32'h0000_0003, 32'h0000_0005, 32'h0, 0, 1, 0,  0, 32'hffff_fffe);
        add_row(ALU_AND,  32'hf0f0_f0f0, 32'hff00_ff00, 32'h0, 0, 1, 0,  0, 32'hf000_f000);
        add_row(ALU_OR,   32'hf0f0_f0f0, 32'h0f0f_0000, 32'h0, 0, 1, 0,  0, 32'hffff_f0f0);
        add_row(ALU_XOR,  32'haaaa_5555, 32'hffff_0000, 32'h0, 0, 1, 0,  0, 32'h5555_5555);
        add_row(ALU_NOR,  32'h0000_ffff, 32'h00ff_0000, 32'h0, 0, 1, 0,  0, 32'hff00_0000);
        add_row(ALU_SLT,  32'hffff_ffff, 32'h0000_0001, 32'h0, 0, 1, 0,  0, 32'h0000_0001);
        add_row(ALU_SLTU, 32'hffff_ffff, 32'h0000_0001, 32'h0, 0, 1, 0,  0, 32'h0000_0000);
        add_row(ALU_SLT,  32'h0000_0005, 32'hffff_fffd, 32'h0, 0, 1, 0,  0, 32'h0000_0000);
        add_row(ALU_SLTU, 32'h0000_0005, 32'hffff_fffd, 32'h0, 0, 1, 0,  0, 32'h0000_0001);
        add_row(ALU_SLL,  32'h0000_0055, 32'h0000_0003, 32'h0, 0, 1, 4,  0, 32'h0000_0030);
        add_row(ALU_SRL,  32'h0000_0000, 32'h8000_0000, 32'h0, 0, 1, 4,  0, 32'h0800_0000);
        add_row(ALU_SRA,  32'h0000_0000, 32'h8000_0000, 32'h0, 0, 1, 4,  0, 32'hf800_0000);
        add_row(ALU_SRA,  32'h0000_0000, 32'h7000_0000, 32'h0, 0, 1, 28, 0, 32'h0000_0007);
        add_row(ALU_SLL,  32'h0000_0000, 32'h0000_0001, 32'h0, 0, 1, 31, 0, 32'h8000_0000);
        add_row(ALU_LUI,  32'h0000_0000, 32'hdead_beef, 32'h1234, 1, 0, 0, 0, 32'h1234_0000);
        add_row(ALU_ADD,  32'h0000_0064, 32'h0000_03e7, 32'hffff_fffc, 1, 0, 0, 0, 32'h60);
        add_row(ALU_ADD,  32'h0000_0001, 32'h0000_0002, 32'h0, 0, 2, 0,  0, 32'h0000_0003);
        add_row(ALU_OR,   32'h0000_0010, 32'h0000_0001, 32'h0, 0, 3, 0,  0, 32'h0000_0011);
        add_row(ALU_XOR,  32'h1234_5678, 32'h1234_5678, 32'h0, 0, 1, 0,  0, 32'h0000_0000);
        // Odd row, so only the link flag marks this bubble.
        add_row(ALU_ADD,  32'h0000_0001, 32'h0000_0001, 32'h0, 0, 1, 0,  1, 32'h0000_0002);
        add_row(ALU_SUB,  32'h0000_0020, 32'h0000_0005, 32'h20, 1, 0, 0, 0, 32'h0000_0000);
        add_row(ALU_SRA,  32'h0000_0000, 32'hffff_fff0, 32'h0, 0, 1, 2,  0, 32'hffff_fffc);
    endtask

    function automatic id_ex_t build_entry(input int idx);
        id_ex_t      e;
        logic [63:0] mix;
        row_t        r;
        r = rows[idx];
        // Varied control bits per row.
        mix = {32'h9e37_79b9 * (idx + 1), 32'h7f4a_7c15 ^ (idx * 32'h0100_0193)};
        e.inst_addr = 32'h0040_0000 + 4 * idx;
        e.rs_data   = r.a;
        e.rt_data   = r.b;
        e.imm_ext   = r.imm;
        e.shamt     = r.sh;
        e.rt_num    = 5'(idx + 2);
        e.rd_num    = 5'(idx + 9);
        e.alu_op    = r.op;
        e.alu_src   = r.src;
        e.dest_sel  = dest_sel_e'(r.dsel);
        e.ctrl      = mix[$bits(ctrl_t)-1:0];
        return e;
    endfunction

    // Reference model for everything beside the ALU result.
    function automatic exp_t model(input id_ex_t e, input logic nop, input logic [31:0] res,
                                   input int idx);
        exp_t x;
        x.idx          = idx;
        x.nop          = nop;
        x.m.alu_result = res;
        x.m.zero       = (res == '0);
        if (e.dest_sel == DEST_RD)
            x.m.wr_num = e.rd_num;
        else if (e.dest_sel == DEST_RA)
            x.m.wr_num = 5'(`RA_REG);
        else
            x.m.wr_num = e.rt_num;
        x.m.rs_data   = e.rs_data;
        x.m.rt_data   = e.rt_data;
        x.m.imm_ext   = e.imm_ext;
        x.m.inst_addr = e.inst_addr;
        x.m.ctrl      = e.ctrl;
        if (nop || e.ctrl.is_nop)
        begin
            x.m.ctrl.reg_write = 1'b0;
            x.m.ctrl.we_cache  = 1'b0;
            x.m.ctrl.we_memory = 1'b0;
        end
        return x;
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp,
                           input int idx);
        if (got !== exp)
        begin
            $display("mismatch at %0t: row %0d %s is %h, expected %h", $time, idx, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_output();
        exp_t x;
        checks++;
        received++;
        if (exp_q.size() == 0)
        begin
            $display("out_valid at %0t with no entry outstanding", $time);
            errors++;
            return;
        end
        x = exp_q.pop_front();
        compare("alu_result", out_entry.alu_result, x.m.alu_result, x.idx);
        compare("zero", out_entry.zero, x.m.zero, x.idx);
        compare("wr_num", out_entry.wr_num, x.m.wr_num, x.idx);
        compare("rs_data", out_entry.rs_data, x.m.rs_data, x.idx);
        compare("rt_data", out_entry.rt_data, x.m.rt_data, x.idx);
        compare("imm_ext", out_entry.imm_ext, x.m.imm_ext, x.idx);
        compare("inst_addr", out_entry.inst_addr, x.m.inst_addr, x.idx);
        compare("ctrl", out_entry.ctrl, x.m.ctrl, x.idx);
        compare("nop", out_nop, x.nop, x.idx);
    endtask

    task automatic tick();
        @(negedge clk);
        if (!rst && in_credit === 1'b1)
        begin
            up_credits++;
            if (up_credits > `EX_CREDITS)
            begin
                $display("in_credit returned more slots than were used, at %0t", $time);
                errors++;
            end
        end
    endtask

    task automatic push_row(input int idx);
        id_ex_t e;
        e = build_entry(idx);
        while (up_credits == 0)
            tick();
        in_valid = 1'b1;
        in_nop   = rows[idx].nop;
        in_entry = e;
        up_credits--;
        exp_q.push_back(model(e, rows[idx].nop, rows[idx].res, idx));
        sent++;
        tick();
        in_valid = 1'b0;
    endtask

    task automatic set_credit_mode(input bit w, input bit r);
        @(posedge clk);
        withhold    = w;
        random_mode = r;
        tick();
    endtask

    task automatic drain();
        while (exp_q.size() != 0)
            tick();
    endtask

    task automatic report_test(input int n, input string name, input int base);
        $display("test %0d (%s) finished with %0d errors", n, name, errors - base);
    endtask

    // Downstream receiver, one out_credit pulse per returned slot.
    initial
    begin
        out_credit = 1'b0;
        forever
        begin
            @(negedge clk);
            out_credit = 1'b0;
            if (!rst && out_valid === 1'b1)
            begin
                check_output();
                owed++;
            end
            if (hold > 0)
                hold--;
            else if (owed > 0 && !withhold)
            begin
                out_credit = 1'b1;
                owed--;
                if (random_mode)
                    hold = $unsigned($random(seed)) % 4;
            end
        end
    end

    initial
    begin
        wait (table_ready);
        repeat (3 * rows.size() * 40 + 5) @(posedge clk);
        $display("run timed out at %0t before all tests finished", $time);
        $display("Something failed");
        $finish;
    end

    initial
    begin
        int idx;
        int idle;
        int base;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_nop   = 1'b0;
        in_entry = '0;
        build_table();
        table_ready = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        base = errors;
        for (idx = 0; idx < rows.size(); idx++)
            push_row(idx);
        drain();
        report_test(1, "directed table", base);

        // Hold back downstream credit until the input side stops.
        base = errors;
        set_credit_mode(1, 0);
        idx  = 0;
        idle = 0;
        while (idle < 12 && idx < rows.size())
        begin
            if (up_credits > 0)
            begin
                push_row(idx);
                idx++;
                idle = 0;
            end
            else
            begin
                tick();
                idle++;
            end
        end
        if (idx == rows.size())
        begin
            $display("in_credit kept coming while downstream credit was withheld");
            errors++;
        end
        if (sent - received > 2 * `EX_CREDITS)
        begin
            $display("%0d entries held inside the unit, more than the queues can store",
                     sent - received);
            errors++;
        end
        set_credit_mode(0, 0);
        while (idx < rows.size())
        begin
            push_row(idx);
            idx++;
        end
        drain();
        report_test(2, "back-pressure", base);

        base = errors;
        set_credit_mode(0, 1);
        for (idx = 0; idx < rows.size(); idx++)
            push_row(idx);
        drain();
        report_test(3, "random credit return", base);

        if (sent != received)
        begin
            $display("output count %0d differs from input count %0d", received, sent);
            errors++;
        end
        $display("sent %0d, received %0d, checks %0d, errors %0d", sent, received, checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/ex_unit_props.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_ex_macros.svh"

module ex_unit_props #(
    parameter int CRD_W = $clog2(`EX_CREDITS + 1)
) (
    input wire logic             clk,
    input wire logic             rst,
    input wire logic             out_valid,
    input wire logic             out_credit,
    input wire logic [CRD_W-1:0] in_cnt,
    input wire logic [CRD_W-1:0] out_cnt
);

    // Entries sent downstream whose slot has not come back yet.
    int outstanding;

    always_ff @(posedge clk)
    begin
        if (rst)
            outstanding <= 0;
        else
            outstanding <= outstanding + int'(out_valid) - int'(out_credit);
    end

    // Counters are unsigned, so an underflow reads as a large value.
    a_in_cnt_range: assert property (@(posedge clk) disable iff (rst) in_cnt <= `EX_CREDITS)
        else $error("input queue credit counter out of range");

    a_out_cnt_range: assert property (@(posedge clk) disable iff (rst) out_cnt <= `EX_CREDITS)
        else $error("output queue credit counter out of range");

    a_valid_needs_credit: assert property (
        @(posedge clk) disable iff (rst) out_valid |-> (outstanding < `EX_CREDITS)
    ) else $error("out_valid without downstream credit");

    a_quiet_in_reset: assert property (@(posedge clk) (rst ##1 rst) |-> !out_valid)
        else $error("out_valid during reset");

endmodule

bind ex_unit_top ex_unit_props u_props (
    .clk        (clk),
    .rst        (rst),
    .out_valid  (out_valid),
    .out_credit (out_credit),
    .in_cnt     (in_q.credits),
    .out_cnt    (out_q.credits)
);

`default_nettype wire

// File: design/ex_unit_top.sv
`timescale 1ns/10ps
`default_nettype none

module ex_unit_top
    import mips_ex_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic in_valid,
    input  wire logic in_nop,
    input  var  id_ex_t in_entry,
    input  wire logic out_credit,
    output logic      in_credit,
    output logic      out_valid,
    output logic      out_nop,
    output ex_mem_t   out_entry
);

    credit_link_if #(.T(id_ex_t))  link_in  ();
    credit_link_if #(.T(id_ex_t))  link_a   ();
    credit_link_if #(.T(ex_mem_t)) link_b   ();
    credit_link_if #(.T(ex_mem_t)) link_out ();

    // Upstream side of the input queue.
    assign link_in.valid   = in_valid;
    assign link_in.nop     = in_nop;
    assign link_in.payload = in_entry;
    assign in_credit       = link_in.credit;

    credit_fifo #(.T(id_ex_t)) in_q (
        .clk  (clk),
        .rst  (rst),
        .up   (link_in.snk),
        .down (link_a.src)
    );

    ex_stage u_ex (
        .id (link_a.snk),
        .ex (link_b.src)
    );

    credit_fifo #(.T(ex_mem_t)) out_q (
        .clk  (clk),
        .rst  (rst),
        .up   (link_b.snk),
        .down (link_out.src)
    );

    // Head of the output queue, toward memory.
    assign out_valid       = link_out.valid;
    assign out_nop         = link_out.nop;
    assign out_entry       = link_out.payload;
    assign link_out.credit = out_credit;

endmodule

`default_nettype wire

// File: design/ex_stage.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_ex_macros.svh"

module ex_stage
    import mips_ex_pkg::*;
(
    credit_link_if.snk id,
    credit_link_if.src ex
);

    localparam logic [`REG_W-1:0] RA_NUM = `RA_REG;

    id_ex_t            entry;
    ex_mem_t           res;
    logic [`XLEN-1:0]  op_b;
    logic [`XLEN-1:0]  alu_result;
    logic              alu_zero;
    logic              bubble;

    assign entry = id.payload;

    // Immediate forms replace rt.
    assign op_b = entry.alu_src ? entry.imm_ext : entry.rt_data;

    // Either the link flag or the decoded nop marks a bubble.
    assign bubble = id.nop | entry.ctrl.is_nop;

    alu u_alu (
        .a      (entry.rs_data),
        .b      (op_b),
        .shamt  (entry.shamt),
        .op     (entry.alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    always_comb
    begin
        res.alu_result = alu_result;
        res.zero       = alu_zero;
        case (entry.dest_sel)
            DEST_RD: res.wr_num = entry.rd_num;
            DEST_RA: res.wr_num = RA_NUM;
            default: res.wr_num = entry.rt_num;
        endcase
        res.rs_data   = entry.rs_data;
        res.rt_data   = entry.rt_data;
        res.imm_ext   = entry.imm_ext;
        res.inst_addr = entry.inst_addr;
        res.ctrl      = entry.ctrl;
        // No architectural writes from a bubble.
        if (bubble)
        begin
            res.ctrl.reg_write = 1'b0;
            res.ctrl.we_cache  = 1'b0;
            res.ctrl.we_memory = 1'b0;
        end
    end

    assign ex.valid   = id.valid;
    assign ex.nop     = id.nop;
    assign ex.payload = res;
    assign id.credit  = ex.credit;

endmodule

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_ex_macros.svh"

module alu
    import mips_ex_pkg::*;
(
    input  wire logic [`XLEN-1:0]  a,
    input  wire logic [`XLEN-1:0]  b,
    input  wire logic [`REG_W-1:0] shamt,
    input  var  alu_op_e           op,
    output logic [`XLEN-1:0]       result,
    output logic                   zero
);

    localparam int HALF = `XLEN / 2;

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb
    begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_NOR:  result = ~(a | b);
            ALU_SLT:  result = {{(`XLEN - 1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(`XLEN - 1){1'b0}}, lt_unsigned};
            // Shifts act on b, as in sll rd, rt, shamt.
            ALU_SLL:  result = b << shamt;
            ALU_SRL:  result = b >> shamt;
            ALU_SRA:  result = $unsigned($signed(b) >>> shamt);
            ALU_LUI:  result = {b[HALF-1:0], {HALF{1'b0}}};
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

// File: design/credit_fifo.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_ex_macros.svh"

module credit_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = `EX_CREDITS
) (
    input wire logic   clk,
    input wire logic   rst,
    credit_link_if.snk up,
    credit_link_if.src down
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CRD_W = $clog2(`EX_CREDITS + 1);

    T                 data_mem [DEPTH];
    logic             nop_mem  [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    logic [CRD_W-1:0] credits;
    logic             send;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1))
            return '0;
        return p + 1'b1;
    endfunction

    // Head leaves once the receiver has room for it.
    assign send = (fill != '0) && (credits != '0);

    assign down.valid   = send;
    assign down.nop     = nop_mem[rd_ptr];
    assign down.payload = data_mem[rd_ptr];
    assign up.credit    = send;

    always_ff @(posedge clk)
    begin
        if (up.valid)
        begin
            data_mem[wr_ptr] <= up.payload;
            nop_mem[wr_ptr]  <= up.nop;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            fill    <= '0;
            credits <= CRD_W'(`EX_CREDITS);
        end
        else
        begin
            if (up.valid)
                wr_ptr <= next_ptr(wr_ptr);
            if (send)
                rd_ptr <= next_ptr(rd_ptr);
            fill    <= fill + CNT_W'(up.valid) - CNT_W'(send);
            // Send and return may happen together.
            credits <= credits + CRD_W'(down.credit) - CRD_W'(send);
        end
    end

endmodule

`default_nettype wire

// File: design/credit_link_if.sv
`timescale 1ns/10ps
`default_nettype none

interface credit_link_if #(
    parameter type T = logic
) ();

    logic valid;
    logic nop;
    T     payload;
    // One pulse returns one slot to the sender.
    logic credit;

    modport src (
        output valid,
        output nop,
        output payload,
        input  credit
    );

    modport snk (
        input  valid,
        input  nop,
        input  payload,
        output credit
    );

endinterface

`default_nettype wire

// File: design/mips_ex_pkg.sv
`default_nettype none
`include "mips_ex_macros.svh"

package mips_ex_pkg;

    typedef enum logic [4:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_AND  = 5'd2,
        ALU_OR   = 5'd3,
        ALU_XOR  = 5'd4,
        ALU_NOR  = 5'd5,
        ALU_SLT  = 5'd6,
        ALU_SLTU = 5'd7,
        ALU_SLL  = 5'd8,
        ALU_SRL  = 5'd9,
        ALU_SRA  = 5'd10,
        ALU_LUI  = 5'd11
    } alu_op_e;

    // Code 3 is decoded as rt.
    typedef enum logic [1:0] {
        DEST_RT = 2'd0,
        DEST_RD = 2'd1,
        DEST_RA = 2'd2
    } dest_sel_e;

    // Bits carried on to memory and writeback.
    typedef struct packed {
        logic        reg_write;
        logic [1:0]  reg_src;
        logic        branch;
        logic        jump;
        logic        jump_reg;
        logic [25:0] jea;
        logic        pc_enable;
        logic        we_cache;
        logic        we_memory;
        logic        cache_input_type;
        logic        set_dirty;
        logic        set_valid;
        logic        mem_addr_type;
        logic        is_word;
        logic        halted;
        logic        is_nop;
    } ctrl_t;

    typedef struct packed {
        logic [`XLEN-1:0]  inst_addr;
        logic [`XLEN-1:0]  rs_data;
        logic [`XLEN-1:0]  rt_data;
        logic [`XLEN-1:0]  imm_ext;
        logic [`REG_W-1:0] shamt;
        logic [`REG_W-1:0] rt_num;
        logic [`REG_W-1:0] rd_num;
        alu_op_e           alu_op;
        logic              alu_src;
        dest_sel_e         dest_sel;
        ctrl_t             ctrl;
    } id_ex_t;

    typedef struct packed {
        logic [`XLEN-1:0]  alu_result;
        logic              zero;
        logic [`REG_W-1:0] wr_num;
        logic [`XLEN-1:0]  rs_data;
        logic [`XLEN-1:0]  rt_data;
        logic [`XLEN-1:0]  imm_ext;
        logic [`XLEN-1:0]  inst_addr;
        ctrl_t             ctrl;
    } ex_mem_t;

endpackage

`default_nettype wire

// File: design/mips_ex_macros.svh
`ifndef MIPS_EX_MACROS_SVH
`define MIPS_EX_MACROS_SVH

// Data path width.
`define XLEN 32

// Register number width.
`define REG_W 5

// Link register written by jal.
`define RA_REG 31

// Queue depth, and the start credit of every sender.
`define EX_CREDITS 2

`endif
